/* common/pipeCtlPkg.sv */
package pipeCtlPkg;

    // number of pipeline stages, which is also the stall/flush vector width
    localparam int NUM_STG = 6;

    // bit positions inside the stall and flush vectors
    localparam int STG_F  = 0;
    localparam int STG_F2 = 1;   // second fetch stage
    localparam int STG_D  = 2;
    localparam int STG_E  = 3;
    localparam int STG_M  = 4;
    localparam int STG_W  = 5;

    // register number width
    localparam int REG_W = 5;

    // instruction class as seen by the control logic in D and E
    typedef enum logic [2:0] {
        opNop    = 3'd0,
        opAlu    = 3'd1,
        opLoad   = 3'd2,   // only class that sets memRead
        opMulDiv = 3'd3,   // multi-cycle unit
        opBranch = 3'd4,
        opJump   = 3'd5
    } opClass_e;

    // operand source for D, higher code means younger producer
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdW    = 2'd1,
        fwdM    = 2'd2,
        fwdE    = 2'd3
    } fwdSel_e;

    // refill controller states
    typedef enum logic [1:0] {
        rfIdle  = 2'd0,
        rfIFill = 2'd1,   // instruction line refill
        rfDFill = 2'd2    // data line refill
    } refillState_e;

endpackage

/* common/stageDestIf.sv */
`timescale 1ns/1ps

// destination info of E, M and W, produced by destPipe and read by hazardUnit
interface stageDestIf import pipeCtlPkg::*; ();

    logic             regWriteE;
    logic             memReadE;
    logic [REG_W-1:0] writeRegE;
    opClass_e         opE;

    logic             regWriteM;
    logic [REG_W-1:0] writeRegM;

    logic             regWriteW;
    logic [REG_W-1:0] writeRegW;

    modport src (
        output regWriteE, memReadE, writeRegE, opE,
        output regWriteM, writeRegM,
        output regWriteW, writeRegW
    );

    modport dst (
        input regWriteE, memReadE, writeRegE, opE,
        input regWriteM, writeRegM,
        input regWriteW, writeRegW
    );

endinterface

/* files.f */
common/pipeCtlPkg.sv
common/stageDestIf.sv
src/stallTimer.sv
src/refillFsm.sv
hazard/destPipe.sv
hazard/hazardUnit.sv
src/pipeCtlTop.sv
tests/tbPipeCtl.sv

/* hazard/destPipe.sv */
`timescale 1ns/1ps

module destPipe import pipeCtlPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic [NUM_STG-1:0] stallVec,
    input  logic [NUM_STG-1:0] flushVec,
    input  logic               eAdvance,
    input  opClass_e           opD,
    input  logic [REG_W-1:0]   writeRegD,
    input  logic               regWriteD,
    stageDestIf.src            dest
);

    opClass_e         opE;
    logic             regWriteE;
    logic [REG_W-1:0] writeRegE;
    logic             regWriteM;
    logic [REG_W-1:0] writeRegM;
    logic             regWriteW;
    logic [REG_W-1:0] writeRegW;

    // E stage, flush beats stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            opE       <= opNop;
            regWriteE <= 1'b0;
            writeRegE <= '0;
        end else if (eAdvance) begin
            if (flushVec[STG_E]) begin
                opE       <= opNop;     // bubble
                regWriteE <= 1'b0;
                writeRegE <= '0;
            end else begin
                opE       <= opD;
                regWriteE <= regWriteD;
                writeRegE <= writeRegD;
            end
        end
    end

    // M stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            writeRegM <= '0;
        end else if (flushVec[STG_M]) begin
            regWriteM <= 1'b0;
            writeRegM <= '0;
        end else if (!stallVec[STG_M]) begin
            regWriteM <= regWriteE;
            writeRegM <= writeRegE;
        end
    end

    // W stage, only ever holds
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
            writeRegW <= '0;
        end else if (!stallVec[STG_W]) begin
            regWriteW <= regWriteM;
            writeRegW <= writeRegM;
        end
    end

    assign dest.opE       = opE;
    assign dest.regWriteE = regWriteE;
    assign dest.writeRegE = writeRegE;
    assign dest.memReadE  = (opE == opLoad);
    assign dest.regWriteM = regWriteM;
    assign dest.writeRegM = writeRegM;
    assign dest.regWriteW = regWriteW;
    assign dest.writeRegW = writeRegW;

    // a flushed stage must come up empty
    aFlushClearsE: assert property (@(posedge clk) disable iff (!rstN)
        flushVec[STG_E] |=> !regWriteE);

endmodule

/* hazard/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import pipeCtlPkg::*; #(
    parameter int MULDIV_CYCLES = 4,
    parameter int TIMER_W       = 4
) (
    input  logic               clk,
    input  logic               rstN,
    stageDestIf.dst            dest,
    input  opClass_e           opD,
    input  logic [REG_W-1:0]   rsD,
    input  logic [REG_W-1:0]   rtD,
    input  logic               predTakeD,
    input  logic               predFailE,
    input  logic               exceptionE,
    input  logic               iCacheStall,
    input  logic               dCacheStall,
    output logic [NUM_STG-1:0] stallVec,
    output logic [NUM_STG-1:0] flushVec,
    output fwdSel_e            fwdRs,
    output fwdSel_e            fwdRt,
    output logic               loadUseStall,
    output logic               eAdvance
);

    logic cacheStall;
    logic baseStall;
    logic aluStallE;
    logic mulDivE;
    logic mdDone;      // result of the op in E is ready
    logic mdStart;
    logic mdBusy;
    logic mdExpired;
    logic redirectD;   // jump or predicted-taken branch in D

    // youngest matching writer wins, r0 never forwards
    function automatic fwdSel_e pickFwd(input logic [REG_W-1:0] src);
        fwdSel_e sel;
        sel = fwdNone;
        if (src != '0) begin
            if (dest.regWriteE && src == dest.writeRegE)
                sel = fwdE;
            else if (dest.regWriteM && src == dest.writeRegM)
                sel = fwdM;
            else if (dest.regWriteW && src == dest.writeRegW)
                sel = fwdW;
        end
        return sel;
    endfunction

    always_comb begin
        fwdRs = pickFwd(rsD);
        fwdRt = pickFwd(rtD);
    end

    // load in E feeding an operand of D
    assign loadUseStall = dest.regWriteE && dest.memReadE
                        && ((rsD != '0 && rsD == dest.writeRegE)
                         || (rtD != '0 && rtD == dest.writeRegE));

    // mul/div holds E until its timer runs out
    assign mulDivE   = (dest.opE == opMulDiv);
    assign aluStallE = mulDivE && !mdDone && !mdExpired;
    assign mdStart   = mulDivE && !mdDone && !mdBusy && !mdExpired;

    assign cacheStall = iCacheStall | dCacheStall;
    assign baseStall  = cacheStall | aluStallE;
    assign redirectD  = (opD == opJump) || (opD == opBranch && predTakeD);

    always_comb begin
        stallVec[STG_F]  = ~exceptionE & (baseStall | loadUseStall); // exception redirects F
        stallVec[STG_F2] = baseStall | loadUseStall;
        stallVec[STG_D]  = baseStall | loadUseStall;
        stallVec[STG_E]  = baseStall;
        stallVec[STG_M]  = baseStall;
        stallVec[STG_W]  = ~exceptionE & baseStall;

        flushVec[STG_F]  = 1'b0;
        flushVec[STG_F2] = exceptionE | predFailE | (redirectD & ~stallVec[STG_F2]);
        flushVec[STG_D]  = exceptionE | (predFailE & ~stallVec[STG_D]);
        flushVec[STG_E]  = exceptionE | (loadUseStall & ~stallVec[STG_E]); // bubble behind load
        flushVec[STG_M]  = exceptionE;
        flushVec[STG_W]  = 1'b0;
    end

    // a flush also replaces the instruction in E
    assign eAdvance = ~stallVec[STG_E] | flushVec[STG_E];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mdDone <= 1'b0;
        end else if (eAdvance) begin
            mdDone <= 1'b0;      // next op in E starts fresh
        end else if (mdExpired) begin
            mdDone <= 1'b1;      // result held while something else stalls
        end
    end

    stallTimer #(
        .CYCLES  (MULDIV_CYCLES),
        .TIMER_W (TIMER_W)
    ) mdTimer (
        .clk     (clk),
        .rstN    (rstN),
        .start   (mdStart),
        .busy    (mdBusy),
        .expired (mdExpired)
    );

    aNoFlushFW: assert property (@(posedge clk) disable iff (!rstN)
        !flushVec[STG_F] && !flushVec[STG_W]);

    aRsZeroNoFwd: assert property (@(posedge clk) disable iff (!rstN)
        (rsD == '0) |-> (fwdRs == fwdNone));

endmodule

/* run.sh */
#!/bin/sh
# build and run the pipeline control testbench with Verilator
verilator --binary --timing -f files.f --top-module tbPipeCtl > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/VtbPipeCtl > sim.log 2>&1 || true
grep -q "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* src/pipeCtlTop.sv */
`timescale 1ns/1ps

module pipeCtlTop import pipeCtlPkg::*; #(
    parameter int REFILL_CYCLES = 6,
    parameter int MULDIV_CYCLES = 4,
    parameter int TIMER_W       = 4
) (
    input  logic               clk,
    input  logic               rstN,
    input  opClass_e           opD,
    input  logic [REG_W-1:0]   rsD,
    input  logic [REG_W-1:0]   rtD,
    input  logic [REG_W-1:0]   writeRegD,
    input  logic               regWriteD,
    input  logic               predTakeD,
    input  logic               predFailE,
    input  logic               exceptionE,
    input  logic               iMiss,
    input  logic               dMiss,
    output logic [NUM_STG-1:0] stallVec,
    output logic [NUM_STG-1:0] flushVec,
    output fwdSel_e            fwdRs,
    output fwdSel_e            fwdRt,
    output logic               loadUseStall,
    output logic               refillBusy
);

    logic iCacheStall;
    logic dCacheStall;
    logic eAdvance;

    stageDestIf destBus ();

    destPipe uDestPipe (
        .clk       (clk),
        .rstN      (rstN),
        .stallVec  (stallVec),
        .flushVec  (flushVec),
        .eAdvance  (eAdvance),
        .opD       (opD),
        .writeRegD (writeRegD),
        .regWriteD (regWriteD),
        .dest      (destBus.src)
    );

    hazardUnit #(
        .MULDIV_CYCLES (MULDIV_CYCLES),
        .TIMER_W       (TIMER_W)
    ) uHazard (
        .clk          (clk),
        .rstN         (rstN),
        .dest         (destBus.dst),
        .opD          (opD),
        .rsD          (rsD),
        .rtD          (rtD),
        .predTakeD    (predTakeD),
        .predFailE    (predFailE),
        .exceptionE   (exceptionE),
        .iCacheStall  (iCacheStall),
        .dCacheStall  (dCacheStall),
        .stallVec     (stallVec),
        .flushVec     (flushVec),
        .fwdRs        (fwdRs),
        .fwdRt        (fwdRt),
        .loadUseStall (loadUseStall),
        .eAdvance     (eAdvance)
    );

    refillFsm #(
        .REFILL_CYCLES (REFILL_CYCLES),
        .TIMER_W       (TIMER_W)
    ) uRefill (
        .clk         (clk),
        .rstN        (rstN),
        .iMiss       (iMiss),
        .dMiss       (dMiss),
        .iCacheStall (iCacheStall),
        .dCacheStall (dCacheStall),
        .refillBusy  (refillBusy)
    );

endmodule

/* src/refillFsm.sv */
`timescale 1ns/1ps

module refillFsm import pipeCtlPkg::*; #(
    parameter int REFILL_CYCLES = 6,
    parameter int TIMER_W       = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic iMiss,
    input  logic dMiss,
    output logic iCacheStall,
    output logic dCacheStall,
    output logic refillBusy
);

    refillState_e state;
    refillState_e stateNext;
    logic         timerStart;
    logic         timerBusy;
    logic         timerExpired;

    // timer kicks off in the miss cycle so the fill state lasts REFILL_CYCLES
    assign timerStart = (state == rfIdle) && (iMiss || dMiss);

    always_comb begin
        stateNext = state;
        case (state)
            rfIdle: begin
                if (dMiss)
                    stateNext = rfDFill;   // data side first
                else if (iMiss)
                    stateNext = rfIFill;
            end
            rfIFill,
            rfDFill: begin
                if (timerExpired)
                    stateNext = rfIdle;
            end
            default: stateNext = rfIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= rfIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign iCacheStall = (state == rfIFill);
    assign dCacheStall = (state == rfDFill);
    assign refillBusy  = (state != rfIdle);

    stallTimer #(
        .CYCLES  (REFILL_CYCLES),
        .TIMER_W (TIMER_W)
    ) fillTimer (
        .clk     (clk),
        .rstN    (rstN),
        .start   (timerStart),
        .busy    (timerBusy),
        .expired (timerExpired)
    );

    aLegalState: assert property (@(posedge clk) disable iff (!rstN)
        state inside {rfIdle, rfIFill, rfDFill});

    // a fill state is always backed by a running or just-expired timer
    aFillTimed: assert property (@(posedge clk) disable iff (!rstN)
        (state != rfIdle) |-> (timerBusy || timerExpired));

endmodule

/* src/stallTimer.sv */
`timescale 1ns/1ps

module stallTimer #(
    parameter int CYCLES  = 4,
    parameter int TIMER_W = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic busy,
    output logic expired
);

    logic [TIMER_W-1:0] count;

    // busy while the count is nonzero
    assign busy = (count != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count   <= '0;
            expired <= 1'b0;
        end else begin
            expired <= (count == TIMER_W'(1));   // lands in the first idle cycle
            if (start && !busy) begin
                count <= TIMER_W'(CYCLES - 1);
            end else if (busy) begin
                count <= count - 1'b1;
            end
        end
    end

    // owners wait for expiry before starting again
    aNoRestart: assert property (@(posedge clk) disable iff (!rstN)
        start |-> !busy);

endmodule

/* tests/pipeCtlVectors.txt */
# name kind(C cycle, R random idle, W wait stall) op rs rt wr rw pt pf ex im dm
#   | stall flush fwdRs fwdRt lu rb n   (hex fields except n, n = cycles for R and W)
fwdAluE    C 1 00 00 05 1 0 0 0 0 0  00 00 0 0 0 0 0
fwdBackE   C 1 05 00 05 1 0 0 0 0 0  00 00 3 0 0 0 0
fwdPrioE   C 0 05 05 00 0 0 0 0 0 0  00 00 3 3 0 0 0
fwdM       C 0 05 00 00 0 0 0 0 0 0  00 00 2 0 0 0 0
fwdW       C 0 00 05 00 0 0 0 0 0 0  00 00 0 1 0 0 0
randIdle   R 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 8
loadIn     C 2 00 00 07 1 0 0 0 0 0  00 00 0 0 0 0 0
loadUse    C 1 03 07 08 1 0 0 0 0 0  07 08 0 3 1 0 0
loadFwdM   C 1 03 07 08 1 0 0 0 0 0  00 00 0 2 0 0 0
loadDrain1 C 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 0
loadDrain2 C 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 0
loadDrain3 C 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 0
brTaken    C 4 00 00 00 0 1 0 0 0 0  00 02 0 0 0 0 0
jumpD      C 5 00 00 00 0 0 0 0 0 0  00 02 0 0 0 0 0
predFail   C 0 00 00 00 0 0 1 0 0 0  00 06 0 0 0 0 0
excIdle    C 0 00 00 00 0 0 0 1 0 0  00 1e 0 0 0 0 0
iMissIn    C 0 00 00 00 0 0 0 0 1 0  00 00 0 0 0 0 0
iFill1     C 0 00 00 00 0 0 0 0 0 0  3f 00 0 0 0 1 0
iFillExc   C 0 00 00 00 0 0 0 1 0 0  1e 1e 0 0 0 1 0
iFillWait  W 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 4
dualMiss   C 0 00 00 00 0 0 0 0 1 1  00 00 0 0 0 0 0
dFillWait  W 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 6
mulDivIn   C 3 00 00 09 1 0 0 0 0 0  00 00 0 0 0 0 0
mulDivWait W 1 09 00 0a 1 0 0 0 0 0  00 00 3 0 0 0 4
mulDivFwdM C 0 09 00 00 0 0 0 0 0 0  00 00 2 0 0 0 0
tailIdle   C 0 00 00 00 0 0 0 0 0 0  00 00 0 0 0 0 0

/* tests/tbPipeCtl.sv */
`timescale 1ns/1ps

module tbPipeCtl import pipeCtlPkg::*; ();

    localparam int WAIT_LIMIT = 50;   // cycles before a wait gives up

    logic               clk;
    logic               rstN;
    opClass_e           opD;
    logic [REG_W-1:0]   rsD;
    logic [REG_W-1:0]   rtD;
    logic [REG_W-1:0]   writeRegD;
    logic               regWriteD;
    logic               predTakeD;
    logic               predFailE;
    logic               exceptionE;
    logic               iMiss;
    logic               dMiss;
    logic [NUM_STG-1:0] stallVec;
    logic [NUM_STG-1:0] flushVec;
    fwdSel_e            fwdRs;
    fwdSel_e            fwdRt;
    logic               loadUseStall;
    logic               refillBusy;

    // fields of the current vector line
    string tName;
    string kind;
    int    opV, rsV, rtV, wrV, rwV, ptV, pfV, exV, imV, dmV;
    int    stallV, flushV, frsV, frtV, luV, rbV, nV;
    logic [31:0] seed;

    // expected E, M and W destinations, moved with the expected stall and flush
    logic             refRw [STG_E:STG_W];
    logic [REG_W-1:0] refWr [STG_E:STG_W];

    pipeCtlTop #(
        .REFILL_CYCLES (6),
        .MULDIV_CYCLES (4),
        .TIMER_W       (4)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // operand source for one register, nearest writer first
    function automatic fwdSel_e expectFwd(input logic [REG_W-1:0] src);
        if (src == '0)
            return fwdNone;
        if (refRw[STG_E] && refWr[STG_E] == src)
            return fwdE;
        if (refRw[STG_M] && refWr[STG_M] == src)
            return fwdM;
        if (refRw[STG_W] && refWr[STG_W] == src)
            return fwdW;
        return fwdNone;
    endfunction

    // one rising edge on the expected destinations, W first so old values move
    task automatic advanceRef(input logic [NUM_STG-1:0] stall,
                              input logic [NUM_STG-1:0] flush);
        if (!stall[STG_W]) begin
            refRw[STG_W] = refRw[STG_M];
            refWr[STG_W] = refWr[STG_M];
        end
        if (flush[STG_M]) begin
            refRw[STG_M] = 1'b0;
            refWr[STG_M] = '0;
        end else if (!stall[STG_M]) begin
            refRw[STG_M] = refRw[STG_E];
            refWr[STG_M] = refWr[STG_E];
        end
        if (flush[STG_E]) begin
            refRw[STG_E] = 1'b0;    // bubble
            refWr[STG_E] = '0;
        end else if (!stall[STG_E]) begin
            refRw[STG_E] = regWriteD;
            refWr[STG_E] = writeRegD;
        end
    endtask

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkFwd(input string what, input fwdSel_e exp, input fwdSel_e act);
        if (exp !== act)
            failNow($sformatf("MISMATCH %s expected %s actual %s", what, exp.name(), act.name()));
    endtask

    task automatic checkVec(input string what, input logic [NUM_STG-1:0] exp,
                            input logic [NUM_STG-1:0] act);
        if (exp !== act)
            failNow($sformatf("MISMATCH %s expected %h actual %h", what, exp, act));
    endtask

    task automatic checkBit(input string what, input logic exp, input logic act);
        if (exp !== act)
            failNow($sformatf("MISMATCH %s expected %b actual %b", what, exp, act));
    endtask

    task automatic checkCount(input string what, input int exp, input int act);
        if (exp != act)
            failNow($sformatf("MISMATCH %s expected %0d actual %0d", what, exp, act));
    endtask

    // drive on the falling edge, sample 10 ns before the next rising edge
    task automatic stepCycle(input logic [REG_W-1:0] rs, input logic [REG_W-1:0] rt);
        @(negedge clk);
        opD        = opClass_e'(opV[2:0]);
        rsD        = rs;
        rtD        = rt;
        writeRegD  = wrV[REG_W-1:0];
        regWriteD  = rwV[0];
        predTakeD  = ptV[0];
        predFailE  = pfV[0];
        exceptionE = exV[0];
        iMiss      = imV[0];
        dMiss      = dmV[0];
        #40;
    endtask

    task automatic checkOutputs();
        checkVec({tName, " stallVec"}, stallV[NUM_STG-1:0], stallVec);
        checkVec({tName, " flushVec"}, flushV[NUM_STG-1:0], flushVec);
        checkFwd({tName, " fwdRs"}, fwdSel_e'(frsV[1:0]), fwdRs);
        checkFwd({tName, " fwdRt"}, fwdSel_e'(frtV[1:0]), fwdRt);
        checkBit({tName, " loadUseStall"}, luV[0], loadUseStall);
        checkBit({tName, " refillBusy"}, rbV[0], refillBusy);
    endtask

    // idle cycles with random sources and a random dead destination
    task automatic randomIdle();
        for (int i = 0; i < nV; i++) begin
            seed = xorshift32(seed);
            wrV  = int'(seed[14:10]);   // regWriteD stays low
            stepCycle(seed[4:0], seed[9:5]);
            frsV = int'(expectFwd(rsD));
            frtV = int'(expectFwd(rtD));
            checkOutputs();
            advanceRef(stallV[NUM_STG-1:0], flushV[NUM_STG-1:0]);
        end
    endtask

    // count stalled cycles until the pipeline moves again
    task automatic waitStall();
        int cnt;
        cnt = 0;
        for (int guard = 0; guard < WAIT_LIMIT; guard++) begin
            stepCycle(rsV[REG_W-1:0], rtV[REG_W-1:0]);
            if (stallVec == '0) begin
                checkCount({tName, " stall cycles"}, nV, cnt);
                checkOutputs();
                advanceRef(stallV[NUM_STG-1:0], flushV[NUM_STG-1:0]);
                return;
            end
            checkVec({tName, " stallVec while busy"}, '1, stallVec);
            checkVec({tName, " flushVec while busy"}, flushV[NUM_STG-1:0], flushVec);
            advanceRef('1, flushV[NUM_STG-1:0]);
            cnt++;
        end
        failNow($sformatf("%s: pipeline still stalled after %0d cycles", tName, WAIT_LIMIT));
    endtask

    initial begin
        int    fd;
        int    got;
        string line;
        seed = 32'hecaf;
        {opV, rsV, rtV, wrV, rwV, ptV, pfV, exV, imV, dmV} = '0;
        foreach (refRw[i]) begin
            refRw[i] = 1'b0;
            refWr[i] = '0;
        end
        rstN = 1'b0;
        opD = opNop;
        rsD = '0;
        rtD = '0;
        writeRegD = '0;
        regWriteD = 1'b0;
        predTakeD = 1'b0;
        predFailE = 1'b0;
        exceptionE = 1'b0;
        iMiss = 1'b0;
        dMiss = 1'b0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;

        fd = $fopen("tests/pipeCtlVectors.txt", "r");
        if (fd == 0)
            failNow("could not open the vector file tests/pipeCtlVectors.txt");
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line[0] == "#")
                continue;
            got = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                          tName, kind, opV, rsV, rtV, wrV, rwV, ptV, pfV, exV, imV, dmV,
                          stallV, flushV, frsV, frtV, luV, rbV, nV);
            if (got != 19)
                failNow({"badly formed vector line: ", line});
            if (kind == "C") begin
                stepCycle(rsV[REG_W-1:0], rtV[REG_W-1:0]);
                checkOutputs();
                advanceRef(stallV[NUM_STG-1:0], flushV[NUM_STG-1:0]);
            end else if (kind == "R") begin
                randomIdle();
            end else if (kind == "W") begin
                waitStall();
            end else begin
                failNow({"unknown line kind in vector file: ", kind});
            end
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule
